//--- axil_cache.f
+incdir+include
design/cache_pkg.sv
design/hold_reg.sv
design/cache_store.sv
design/cache_ctrl.sv
design/axil_cache.sv
tb/tb_mem_model.sv
tb/tb_axil_cache.sv

//--- design/axil_cache.sv
`timescale 1ns/10ps
`default_nettype none

module axil_cache (
  input  wire                      ACLK,
  input  wire                      ARESETn,
  // Processor read
  input  wire                      rd_req_valid,
  output logic                     rd_req_ready,
  input  wire  cache_pkg::addr_t   rd_req_addr,
  output logic                     rd_rsp_valid,
  input  wire                      rd_rsp_ready,
  output cache_pkg::word_t         rd_rsp_data,
  // Processor write
  input  wire                      wr_req_valid,
  output logic                     wr_req_ready,
  input  wire  cache_pkg::wr_req_t wr_req,
  output logic                     wr_rsp_valid,
  input  wire                      wr_rsp_ready,
  // Memory fill
  output logic                     fill_req_valid,
  input  wire                      fill_req_ready,
  output cache_pkg::addr_t         fill_req_addr,
  input  wire                      fill_rsp_valid,
  output logic                     fill_rsp_ready,
  input  wire  cache_pkg::word_t   fill_rsp_data,
  // Memory writeback
  output logic                     wb_req_valid,
  input  wire                      wb_req_ready,
  output cache_pkg::wb_req_t       wb_req,
  input  wire                      wb_rsp_valid,
  output logic                     wb_rsp_ready
);

  import cache_pkg::*;

  // Store interface
  addr_t   lookup_addr;
  logic    hit;
  logic    victim_dirty;
  addr_t   victim_addr;
  word_t   line_data;
  logic    wr_en;
  word_t   wr_data;
  strb_t   wr_strb;
  logic    fill_en;

  // Hold register strobes
  logic    rsp_load;
  word_t   rsp_word;
  logic    rsp_taken;
  logic    fill_load;
  logic    fill_taken;
  logic    wb_load;
  logic    wb_taken;
  wb_req_t wb_payload;

  // Victim line as seen by the store
  assign wb_payload = '{addr: victim_addr, data: line_data};

  cache_ctrl u_ctrl (
    .ACLK           (ACLK),
    .ARESETn        (ARESETn),
    .rd_req_valid   (rd_req_valid),
    .rd_req_ready   (rd_req_ready),
    .rd_req_addr    (rd_req_addr),
    .wr_req_valid   (wr_req_valid),
    .wr_req_ready   (wr_req_ready),
    .wr_req         (wr_req),
    .wr_rsp_valid   (wr_rsp_valid),
    .wr_rsp_ready   (wr_rsp_ready),
    .rsp_load       (rsp_load),
    .rsp_word       (rsp_word),
    .rsp_taken      (rsp_taken),
    .fill_load      (fill_load),
    .fill_taken     (fill_taken),
    .fill_rsp_valid (fill_rsp_valid),
    .fill_rsp_ready (fill_rsp_ready),
    .fill_rsp_data  (fill_rsp_data),
    .wb_load        (wb_load),
    .wb_taken       (wb_taken),
    .wb_rsp_valid   (wb_rsp_valid),
    .wb_rsp_ready   (wb_rsp_ready),
    .lookup_addr    (lookup_addr),
    .hit            (hit),
    .victim_dirty   (victim_dirty),
    .line_data      (line_data),
    .wr_en          (wr_en),
    .wr_data        (wr_data),
    .wr_strb        (wr_strb),
    .fill_en        (fill_en)
  );

  cache_store u_store (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .lookup_addr  (lookup_addr),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_addr  (victim_addr),
    .line_data    (line_data),
    .wr_en        (wr_en),
    .wr_data      (wr_data),
    .wr_strb      (wr_strb),
    .fill_en      (fill_en),
    .fill_data    (fill_rsp_data)
  );

  // Read data back to the processor
  hold_reg #(.payload_t(word_t)) u_rd_rsp (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (rsp_load),
    .load_data (rsp_word),
    .valid     (rd_rsp_valid),
    .ready     (rd_rsp_ready),
    .data      (rd_rsp_data),
    .taken     (rsp_taken)
  );

  // Fill address is the current lookup address
  hold_reg #(.payload_t(addr_t)) u_fill_req (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (fill_load),
    .load_data (lookup_addr),
    .valid     (fill_req_valid),
    .ready     (fill_req_ready),
    .data      (fill_req_addr),
    .taken     (fill_taken)
  );

  hold_reg #(.payload_t(wb_req_t)) u_wb_req (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .load      (wb_load),
    .load_data (wb_payload),
    .valid     (wb_req_valid),
    .ready     (wb_req_ready),
    .data      (wb_req),
    .taken     (wb_taken)
  );

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_macros.svh"

module cache_ctrl (
  input  wire                        ACLK,
  input  wire                        ARESETn,
  // Processor read request
  input  wire                        rd_req_valid,
  output logic                       rd_req_ready,
  input  wire  cache_pkg::addr_t     rd_req_addr,
  // Processor write request and response
  input  wire                        wr_req_valid,
  output logic                       wr_req_ready,
  input  wire  cache_pkg::wr_req_t   wr_req,
  output logic                       wr_rsp_valid,
  input  wire                        wr_rsp_ready,
  // Read response register
  output logic                       rsp_load,
  output cache_pkg::word_t           rsp_word,
  input  wire                        rsp_taken,
  // Fill channels
  output logic                       fill_load,
  input  wire                        fill_taken,
  input  wire                        fill_rsp_valid,
  output logic                       fill_rsp_ready,
  input  wire  cache_pkg::word_t     fill_rsp_data,
  // Writeback channels
  output logic                       wb_load,
  input  wire                        wb_taken,
  input  wire                        wb_rsp_valid,
  output logic                       wb_rsp_ready,
  // Store lookup and commands
  output cache_pkg::addr_t           lookup_addr,
  input  wire                        hit,
  input  wire                        victim_dirty,
  input  wire  cache_pkg::word_t     line_data,
  output logic                       wr_en,
  output cache_pkg::word_t           wr_data,
  output cache_pkg::strb_t           wr_strb,
  output logic                       fill_en
);

  import cache_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // Latched request, held for the whole miss
  wr_req_t req_q;
  logic    is_wr_q;

  // Memory request has left the hold register
  logic    mem_sent_q;

  wr_req_t cur_req;
  logic    cur_is_wr;
  logic    idle;
  logic    rd_fire;
  logic    wr_fire;
  logic    accept;
  logic    fill_fire;
  logic    wb_fire;
  logic    rsp_done;

  assign idle = (state_q == ST_IDLE);

  // Read wins when both are valid
  assign rd_req_ready = idle;
  assign wr_req_ready = idle && !rd_req_valid;

  assign rd_fire = rd_req_valid && rd_req_ready;
  assign wr_fire = wr_req_valid && wr_req_ready;
  assign accept  = rd_fire || wr_fire;

  // Incoming request in idle, latched one otherwise
  always_comb begin
    if (idle) begin
      if (rd_req_valid) begin
        cur_req   = '{addr: rd_req_addr, data: '0, strb: '0};
        cur_is_wr = 1'b0;
      end else begin
        cur_req   = wr_req;
        cur_is_wr = 1'b1;
      end
    end else begin
      cur_req   = req_q;
      cur_is_wr = is_wr_q;
    end
  end

  assign lookup_addr = cur_req.addr;
  assign wr_data     = cur_req.data;
  assign wr_strb     = cur_req.strb;

  // Only listen for a response once the request went out
  assign fill_rsp_ready = (state_q == ST_FILL) && mem_sent_q;
  assign wb_rsp_ready   = (state_q == ST_WRITEBACK) && mem_sent_q;

  assign fill_fire = fill_rsp_valid && fill_rsp_ready;
  assign wb_fire   = wb_rsp_valid && wb_rsp_ready;

  assign rsp_done = is_wr_q ? (wr_rsp_valid && wr_rsp_ready) : rsp_taken;

  // Next state and one-cycle strobes
  always_comb begin
    state_d   = state_q;
    rsp_load  = 1'b0;
    rsp_word  = line_data;
    fill_load = 1'b0;
    wb_load   = 1'b0;
    wr_en     = 1'b0;
    fill_en   = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          if (hit) begin
            // Answer from the array right away
            wr_en    = cur_is_wr;
            rsp_load = !cur_is_wr;
            state_d  = ST_RESPOND;
          end else if (victim_dirty) begin
            // Victim data and address come straight from the store
            wb_load = 1'b1;
            state_d = ST_WRITEBACK;
          end else begin
            fill_load = 1'b1;
            state_d   = ST_FILL;
          end
        end
      end
      ST_WRITEBACK: begin
        // Memory has the old line, fetch the new one
        if (wb_fire) begin
          fill_load = 1'b1;
          state_d   = ST_FILL;
        end
      end
      ST_FILL: begin
        if (fill_fire) begin
          fill_en  = 1'b1;
          wr_en    = is_wr_q;
          rsp_load = !is_wr_q;
          // Forward the fill word
          rsp_word = fill_rsp_data;
          state_d  = ST_RESPOND;
        end
      end
      ST_RESPOND: begin
        if (rsp_done) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      state_q      <= ST_IDLE;
      wr_rsp_valid <= 1'b0;
      mem_sent_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      // Every write completes with a store write
      if (wr_en) begin
        wr_rsp_valid <= 1'b1;
      end else if (wr_rsp_ready) begin
        wr_rsp_valid <= 1'b0;
      end
      if (fill_fire || wb_fire) begin
        mem_sent_q <= 1'b0;
      end else if (fill_taken || wb_taken) begin
        mem_sent_q <= 1'b1;
      end
    end
  end

  // Request capture
  always_ff @(posedge ACLK) begin
    if (accept) begin
      req_q   <= cur_req;
      is_wr_q <= cur_is_wr;
    end
  end

  // One-word lines, word-aligned accesses only
  a_rd_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_req_valid |-> rd_req_addr[`CACHE_OFFSET_W-1:0] == '0);
  a_wr_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wr_req_valid |-> wr_req.addr[`CACHE_OFFSET_W-1:0] == '0);

  // Memory only answers a fill we actually sent
  a_fill_in_state: assert property (@(posedge ACLK) disable iff (!ARESETn)
    fill_rsp_valid |-> state_q == ST_FILL && mem_sent_q);

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

  `include "cache_macros.svh"

  typedef logic [`CACHE_ADDR_W-1:0]  addr_t;
  typedef logic [`CACHE_DATA_W-1:0]  word_t;
  typedef logic [`CACHE_STRB_W-1:0]  strb_t;
  typedef logic [`CACHE_INDEX_W-1:0] index_t;
  typedef logic [`CACHE_TAG_W-1:0]   tag_t;

  // Processor write, address and data channels merged
  typedef struct packed {
    addr_t addr;
    word_t data;
    strb_t strb;
  } wr_req_t;

  // Full-word writeback of a dirty victim
  typedef struct packed {
    addr_t addr;
    word_t data;
  } wb_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITEBACK,
    ST_FILL,
    ST_RESPOND
  } ctrl_state_t;

  function automatic index_t addr_index(addr_t a);
    return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  endfunction

  function automatic tag_t addr_tag(addr_t a);
    return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  endfunction

  // Byte lanes with strobe set come from new_w
  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int i = 0; i < `CACHE_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

//--- design/cache_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_macros.svh"

module cache_store (
  input  wire                    ACLK,
  input  wire                    ARESETn,
  // Lookup
  input  wire  cache_pkg::addr_t lookup_addr,
  output logic                   hit,
  output logic                   victim_dirty,
  output cache_pkg::addr_t       victim_addr,
  output cache_pkg::word_t       line_data,
  // Processor write merge
  input  wire                    wr_en,
  input  wire  cache_pkg::word_t wr_data,
  input  wire  cache_pkg::strb_t wr_strb,
  // Line fill from memory
  input  wire                    fill_en,
  input  wire  cache_pkg::word_t fill_data
);

  import cache_pkg::*;

  // Line arrays
  tag_t                       tag_q  [`CACHE_NUM_SETS];
  word_t                      data_q [`CACHE_NUM_SETS];
  logic [`CACHE_NUM_SETS-1:0] valid_q;
  logic [`CACHE_NUM_SETS-1:0] dirty_q;

  index_t idx;
  tag_t   lk_tag;

  assign idx    = addr_index(lookup_addr);
  assign lk_tag = addr_tag(lookup_addr);

  // Tag compare against the single candidate line
  assign hit          = valid_q[idx] && (tag_q[idx] == lk_tag);
  // Occupant needs writing back before it is replaced
  assign victim_dirty = valid_q[idx] && dirty_q[idx];
  // Rebuild the occupant's address from its stored tag
  assign victim_addr  = {tag_q[idx], idx, {`CACHE_OFFSET_W{1'b0}}};
  assign line_data    = data_q[idx];

  // Tag and data updates
  always_ff @(posedge ACLK) begin
    if (fill_en) begin
      tag_q[idx] <= lk_tag;
      // Write miss completes here, write bytes land on top of the fill word
      if (wr_en) begin
        data_q[idx] <= merge_bytes(fill_data, wr_data, wr_strb);
      end else begin
        data_q[idx] <= fill_data;
      end
    end else if (wr_en) begin
      data_q[idx] <= merge_bytes(data_q[idx], wr_data, wr_strb);
    end
  end

  // Line state bits
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      valid_q[idx] <= 1'b1;
      // Clean after a read fill, dirty after a write fill
      dirty_q[idx] <= wr_en;
    end else if (wr_en) begin
      dirty_q[idx] <= 1'b1;
    end
  end

  // Plain write only lands on a resident line
  a_write_on_hit: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wr_en && !fill_en |-> hit);

  // Filled line is resident on the next cycle, control keeps the address
  a_fill_resident: assert property (@(posedge ACLK) disable iff (!ARESETn)
    fill_en |=> hit);

endmodule

`default_nettype wire

//--- design/hold_reg.sv
`timescale 1ns/10ps
`default_nettype none

module hold_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  wire           ACLK,
  input  wire           ARESETn,
  input  wire           load,
  input  wire payload_t load_data,
  output logic          valid,
  input  wire           ready,
  output payload_t      data,
  output logic          taken
);

  // Transfer on this edge
  assign taken = valid && ready;

  // Valid rises after a load and falls after the transfer
  always_ff @(posedge ACLK) begin
    if (!ARESETn) begin
      valid <= 1'b0;
    end else if (load) begin
      valid <= 1'b1;
    end else if (taken) begin
      valid <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge ACLK) begin
    if (load) data <= load_data;
  end

  // Held transfer keeps valid and payload until accepted
  a_hold_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
    valid && !ready |=> valid && $stable(data));

  // Producer only loads an empty register
  a_no_overwrite: assert property (@(posedge ACLK) disable iff (!ARESETn)
    load |-> !valid);

endmodule

`default_nettype wire

//--- include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Bus widths
`define CACHE_ADDR_W   32
`define CACHE_DATA_W   32
`define CACHE_STRB_W   (`CACHE_DATA_W / 8)

// Geometry: one word per line, direct mapped
`define CACHE_NUM_SETS 4
`define CACHE_OFFSET_W 2
`define CACHE_INDEX_W  $clog2(`CACHE_NUM_SETS)

// Tag takes whatever the index and byte offset leave over
`define CACHE_TAG_W    (`CACHE_ADDR_W - `CACHE_INDEX_W - `CACHE_OFFSET_W)

`endif

//--- tb/tb_axil_cache.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_macros.svh"

module tb_axil_cache;

  import cache_pkg::*;

  localparam int    CLK_HALF     = 50;
  localparam int    MEM_WORDS    = 64;
  localparam word_t FILL_XOR     = 32'h5a3c_96e1;
  localparam int    NUM_DIRECTED = 16;
  localparam int    NUM_RANDOM   = 64;

  logic    ACLK;
  logic    ARESETn;
  logic    rd_req_valid;
  logic    rd_req_ready;
  addr_t   rd_req_addr;
  logic    rd_rsp_valid;
  logic    rd_rsp_ready;
  word_t   rd_rsp_data;
  logic    wr_req_valid;
  logic    wr_req_ready;
  wr_req_t wr_req;
  logic    wr_rsp_valid;
  logic    wr_rsp_ready;
  logic    fill_req_valid;
  logic    fill_req_ready;
  addr_t   fill_req_addr;
  logic    fill_rsp_valid;
  logic    fill_rsp_ready;
  word_t   fill_rsp_data;
  logic    wb_req_valid;
  logic    wb_req_ready;
  wb_req_t wb_req;
  logic    wb_rsp_valid;
  logic    wb_rsp_ready;

  // Processor view of memory, and which address each line holds
  word_t shadow     [MEM_WORDS];
  addr_t line_addr  [`CACHE_NUM_SETS];
  logic  line_valid [`CACHE_NUM_SETS];
  logic  line_dirty [`CACHE_NUM_SETS];

  // Expectations for the request in flight
  string       test_name;
  addr_t       cur_addr;
  word_t       exp_rd_data;
  logic        exp_hit;
  logic        exp_wb;
  addr_t       exp_wb_addr;
  word_t       exp_wb_data;
  int          wb_count = 0;
  int          wb_start;
  word_t       prev_rd_data;
  logic [31:0] ready_bits;
  integer      seed = 32'h8f38;

  initial begin
    ACLK = 1'b0;
    forever #CLK_HALF ACLK = ~ACLK;
  end

  axil_cache u_dut (.*);

  tb_mem_model #(.MEM_WORDS(MEM_WORDS), .FILL_XOR(FILL_XOR)) u_mem (.*);

  // Draw on the rising edge, apply on the falling one
  always @(posedge ACLK) begin
    ready_bits   <= $random(seed);
    prev_rd_data <= rd_rsp_data;
    if (wb_rsp_valid && wb_rsp_ready) wb_count <= wb_count + 1;
  end

  // Processor stalls responses about a quarter of the time
  always @(negedge ACLK) begin
    rd_rsp_ready = (ready_bits[1:0] != 2'b00);
    wr_rsp_ready = (ready_bits[3:2] != 2'b00);
  end

  task automatic end_with_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic report_mismatch(string check, logic [31:0] exp, logic [31:0] act);
    $display("Fail %s/%s: expected %h, actual %h", test_name, check, exp, act);
    end_with_error();
  endtask

  task automatic report_problem(string what);
    $display("Error in %s: %s", test_name, what);
    end_with_error();
  endtask

  // Byte lanes under the strobes take the new data
  function automatic word_t apply_strobes(word_t old_w, word_t new_w, strb_t st);
    word_t mask;
    mask = {{8{st[3]}}, {8{st[2]}}, {8{st[1]}}, {8{st[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic int word_of(addr_t a);
    return a[2 +: $clog2(MEM_WORDS)];
  endfunction

  function automatic int set_of(addr_t a);
    return a[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
  endfunction

  // Predict hit, victim and read data before the request goes out
  task automatic set_expect(addr_t a);
    int s;
    s           = set_of(a);
    cur_addr    = a;
    exp_rd_data = shadow[word_of(a)];
    exp_hit     = line_valid[s] && (line_addr[s] == a);
    exp_wb      = !exp_hit && line_valid[s] && line_dirty[s];
    exp_wb_addr = line_addr[s];
    exp_wb_data = shadow[word_of(line_addr[s])];
    wb_start    = wb_count;
  endtask

  task automatic update_lines(addr_t a, logic wrote);
    int s;
    s             = set_of(a);
    line_dirty[s] = wrote || (exp_hit && line_dirty[s]);
    line_valid[s] = 1'b1;
    line_addr[s]  = a;
  endtask

  task automatic cache_read(addr_t a);
    @(negedge ACLK);
    set_expect(a);
    rd_req_addr  = a;
    rd_req_valid = 1'b1;
    do @(posedge ACLK); while (!rd_req_ready);
    @(negedge ACLK);
    rd_req_valid = 1'b0;
    do @(posedge ACLK); while (!(rd_rsp_valid && rd_rsp_ready));
    update_lines(a, 1'b0);
  endtask

  task automatic cache_write(addr_t a, word_t d, strb_t st);
    @(negedge ACLK);
    set_expect(a);
    wr_req       = '{addr: a, data: d, strb: st};
    wr_req_valid = 1'b1;
    do @(posedge ACLK); while (!wr_req_ready);
    @(negedge ACLK);
    wr_req_valid = 1'b0;
    do @(posedge ACLK); while (!(wr_rsp_valid && wr_rsp_ready));
    shadow[word_of(a)] = apply_strobes(shadow[word_of(a)], d, st);
    update_lines(a, 1'b1);
  endtask

  // Read data, for misses, hits and merged partial writes
  a_rd_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_rsp_valid |-> rd_rsp_data == exp_rd_data)
    else report_mismatch("rd_data", $sampled(exp_rd_data), $sampled(rd_rsp_data));

  // Hits answer on the next edge
  a_rd_hit_latency: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_req_valid && rd_req_ready && exp_hit |=> rd_rsp_valid)
    else report_mismatch("rd_hit_latency", 1, $sampled(rd_rsp_valid));
  a_wr_hit_latency: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wr_req_valid && wr_req_ready && exp_hit |=> wr_rsp_valid)
    else report_mismatch("wr_hit_latency", 1, $sampled(wr_rsp_valid));
  a_hit_no_mem: assert property (@(posedge ACLK) disable iff (!ARESETn)
    exp_hit |-> !fill_req_valid && !wb_req_valid)
    else report_problem("memory request issued on a cache hit");

  // Dirty victim goes out first, with its own address and latest data
  a_wb_expected: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wb_req_valid |-> exp_wb)
    else report_problem("writeback issued without a dirty victim");
  a_wb_addr: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wb_req_valid |-> wb_req.addr == exp_wb_addr)
    else report_mismatch("wb_addr", $sampled(exp_wb_addr), $sampled(wb_req.addr));
  a_wb_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wb_req_valid |-> wb_req.data == exp_wb_data)
    else report_mismatch("wb_data", $sampled(exp_wb_data), $sampled(wb_req.data));
  a_wb_first: assert property (@(posedge ACLK) disable iff (!ARESETn)
    fill_req_valid && exp_wb |-> wb_count != wb_start)
    else report_problem("fill request issued before the victim writeback finished");
  a_fill_addr: assert property (@(posedge ACLK) disable iff (!ARESETn)
    fill_req_valid |-> fill_req_addr == cur_addr)
    else report_mismatch("fill_addr", $sampled(cur_addr), $sampled(fill_req_addr));

  // Stalled responses hold, and nothing new is accepted meanwhile
  a_rd_hold_valid: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid)
    else report_problem("read response dropped before it was taken");
  a_rd_hold_data: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_data == prev_rd_data)
    else report_mismatch("rd_hold_data", $sampled(prev_rd_data), $sampled(rd_rsp_data));
  a_wr_hold_valid: assert property (@(posedge ACLK) disable iff (!ARESETn)
    wr_rsp_valid && !wr_rsp_ready |=> wr_rsp_valid)
    else report_problem("write response dropped before it was taken");
  a_no_accept: assert property (@(posedge ACLK) disable iff (!ARESETn)
    rd_rsp_valid || wr_rsp_valid |-> !rd_req_ready && !wr_req_ready)
    else report_problem("request ready while a response is pending");

  // Each request gets 200 cycles
  initial begin : watchdog
    repeat ((NUM_DIRECTED + NUM_RANDOM) * 200) @(posedge ACLK);
    report_problem("watchdog expired, a request never completed");
  end

  initial begin : stimulus
    logic [31:0] r;
    word_t       d;
    addr_t       a;
    ARESETn      = 1'b0;
    rd_req_valid = 1'b0;
    rd_req_addr  = '0;
    wr_req_valid = 1'b0;
    wr_req       = '0;
    rd_rsp_ready = 1'b0;
    wr_rsp_ready = 1'b0;
    test_name    = "reset";
    cur_addr     = '0;
    exp_hit      = 1'b0;
    exp_wb       = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = addr_t'(i * 4) ^ FILL_XOR;
    end
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      line_valid[s] = 1'b0;
      line_dirty[s] = 1'b0;
    end
    repeat (5) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1;

    // Cold misses in every set, then the same words as hits
    test_name = "read_miss";
    for (int i = 0; i < 4; i++) cache_read(addr_t'(i * 4));
    test_name = "read_hit";
    for (int i = 0; i < 4; i++) cache_read(addr_t'(i * 4));

    // Write hit, then write miss over a clean line
    test_name = "partial_write";
    cache_write(32'h04, 32'hdead_beef, 4'b0101);
    cache_write(32'h20, 32'h1234_5678, 4'b1100);
    cache_read(32'h04);
    cache_read(32'h20);

    // First three replace a dirty line and the last reads the merged word back
    test_name = "dirty_evict";
    cache_read(32'h40);
    cache_write(32'h44, 32'hcafe_f00d, 4'b0011);
    cache_read(32'h04);
    cache_read(32'h44);

    // Mixed traffic over eight tags, responses stalled at random
    test_name = "random_backpressure";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      @(negedge ACLK);
      r = $random(seed);
      d = $random(seed);
      a = addr_t'({r[4:0], 2'b00});
      if (r[5]) begin
        cache_write(a, d, r[9:6]);
      end else begin
        cache_read(a);
      end
    end

    repeat (4) @(negedge ACLK);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mem_model #(
  parameter int               MEM_WORDS = 64,
  parameter cache_pkg::word_t FILL_XOR  = '0
) (
  input  wire                      ACLK,
  input  wire                      ARESETn,
  // Fill channels
  input  wire                      fill_req_valid,
  output logic                     fill_req_ready,
  input  wire  cache_pkg::addr_t   fill_req_addr,
  output logic                     fill_rsp_valid,
  input  wire                      fill_rsp_ready,
  output cache_pkg::word_t         fill_rsp_data,
  // Writeback channels
  input  wire                      wb_req_valid,
  output logic                     wb_req_ready,
  input  wire  cache_pkg::wb_req_t wb_req,
  output logic                     wb_rsp_valid,
  input  wire                      wb_rsp_ready
);

  import cache_pkg::*;

  localparam int WORD_BITS = $clog2(MEM_WORDS);

  // Reference memory, one entry per word address
  word_t       mem [MEM_WORDS];
  integer      seed = 32'h8f38;
  logic [31:0] rnd;

  // Fresh random bits each cycle, read on the falling edge
  always @(posedge ACLK) begin
    rnd <= $random(seed);
  end

  // Fill side
  initial begin : fill_side
    addr_t a;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = addr_t'(i * 4) ^ FILL_XOR;
    end
    fill_req_ready = 1'b0;
    fill_rsp_valid = 1'b0;
    fill_rsp_data  = '0;
    forever begin
      // Ready comes and goes until a request is taken
      do begin
        @(negedge ACLK);
        fill_req_ready = (rnd[1:0] != 2'b00);
        @(posedge ACLK);
      end while (!(ARESETn && fill_req_valid && fill_req_ready));
      a = fill_req_addr;
      @(negedge ACLK);
      fill_req_ready = 1'b0;
      // Random access latency
      repeat (rnd[4:2]) @(negedge ACLK);
      fill_rsp_data  = mem[a[2 +: WORD_BITS]];
      fill_rsp_valid = 1'b1;
      do @(posedge ACLK); while (!fill_rsp_ready);
      @(negedge ACLK);
      fill_rsp_valid = 1'b0;
    end
  end

  // Writeback side
  initial begin : wb_side
    wb_req_ready = 1'b0;
    wb_rsp_valid = 1'b0;
    forever begin
      do begin
        @(negedge ACLK);
        wb_req_ready = (rnd[6:5] != 2'b00);
        @(posedge ACLK);
      end while (!(ARESETn && wb_req_valid && wb_req_ready));
      // Victim word lands in memory on the transfer edge
      mem[wb_req.addr[2 +: WORD_BITS]] = wb_req.data;
      @(negedge ACLK);
      wb_req_ready = 1'b0;
      repeat (rnd[9:7]) @(negedge ACLK);
      wb_rsp_valid = 1'b1;
      do @(posedge ACLK); while (!wb_rsp_ready);
      @(negedge ACLK);
      wb_rsp_valid = 1'b0;
    end
  end

endmodule

`default_nettype wire
